/* verilog/mouse_gui_params.svh */
// ==============================
// timing is fixed 640x480 at one pixel per clk_pixel cycle
// block shifts must leave an 11-bit table address
// ==============================
`ifndef MOUSE_GUI_PARAMS_SVH
`define MOUSE_GUI_PARAMS_SVH

// PS/2 receive side
`define PS2_SYNC_STAGES 2
`define PS2_FRAME_BITS  11

// horizontal timing in pixels
`define H_ACTIVE     640
`define H_SYNC_START 656
`define H_SYNC_END   752
`define H_TOTAL      800

// vertical timing in lines
`define V_ACTIVE     480
`define V_SYNC_START 490
`define V_SYNC_END   492
`define V_TOTAL      525

// canvas blocks are 32x16 pixels
`define BLOCK_X_SHIFT 5
`define BLOCK_Y_SHIFT 4
`define CROSSHAIR_COLOR 9'h1FF

`endif

/* verilog/mouse_gui_pkg.sv */
// ==============================
// coordinates are 10 bits wide, enough for 640x480 plus blanking
// ==============================
package mouse_gui_pkg;

    // 3:3:3 color, red in the top bits
    typedef struct packed {
        logic [2:0] r;
        logic [2:0] g;
        logic [2:0] b;
    } color_t;

    // bit order matches byte 0 of a PS/2 movement packet
    typedef struct packed {
        logic middle;
        logic right;
        logic left;
    } buttons_t;

    typedef struct packed {
        logic [9:0] x;
        logic [9:0] y;
        buttons_t   buttons;
    } mouse_state_t;

    // sync lines are active low
    typedef struct packed {
        logic [9:0] x;
        logic [9:0] y;
        logic       hsync;
        logic       vsync;
        logic       blank;
    } beam_t;

    typedef struct packed {
        beam_t  beam;
        color_t color;
    } pixel_out_t;

endpackage

/* verilog/ps2_frame_rx.sv */
// ==============================
// receive only, the device must already be streaming
// bad parity or stop bit drops the frame silently
// ==============================
`timescale 1ns/1ps
`include "mouse_gui_params.svh"

module ps2_frame_rx
(
    input  logic       clk_pixel,
    input  logic       rst_n,
    input  logic       ps2_clk,
    input  logic       ps2_data,
    output logic [7:0] byte_data,
    output logic       byte_valid
);

    logic [`PS2_SYNC_STAGES-1:0] clk_sync;
    logic [`PS2_SYNC_STAGES-1:0] data_sync;
    logic                        clk_prev;
    logic                        clk_fall;
    logic                        data_bit;
    logic [3:0]                  bit_cnt;
    logic [7:0]                  shift_reg;
    logic                        parity_bit;
    logic                        stop_slot;
    logic                        frame_ok;

    // both lines idle high, so the synchronizer comes out of reset at ones
    always_ff @(posedge clk_pixel or negedge rst_n)
    begin
        if (!rst_n)
        begin
            clk_sync  <= '1;
            data_sync <= '1;
            clk_prev  <= 1'b1;
        end
        else
        begin
            clk_sync  <= {clk_sync[`PS2_SYNC_STAGES-2:0], ps2_clk};
            data_sync <= {data_sync[`PS2_SYNC_STAGES-2:0], ps2_data};
            clk_prev  <= clk_sync[`PS2_SYNC_STAGES-1];
        end
    end

    assign clk_fall  = clk_prev & ~clk_sync[`PS2_SYNC_STAGES-1];
    assign data_bit  = data_sync[`PS2_SYNC_STAGES-1];
    assign stop_slot = (bit_cnt == 4'(`PS2_FRAME_BITS - 1));

    // odd parity over data plus parity bit, stop bit must read high
    assign frame_ok = clk_fall & stop_slot & data_bit & (^{shift_reg, parity_bit});

    always_ff @(posedge clk_pixel or negedge rst_n)
    begin
        if (!rst_n)
        begin
            bit_cnt    <= '0;
            byte_valid <= 1'b0;
        end
        else
        begin
            byte_valid <= frame_ok;
            if (clk_fall)
            begin
                if (bit_cnt == 4'd0)
                begin
                    // hunt for a start bit of 0
                    if (!data_bit)
                        bit_cnt <= 4'd1;
                end
                else if (stop_slot)
                    bit_cnt <= '0;
                else
                    bit_cnt <= bit_cnt + 4'd1;
            end
        end
    end

    // data arrives LSB first, so shift in from the top
    always_ff @(posedge clk_pixel)
    begin
        if (clk_fall && (bit_cnt >= 4'd1) && (bit_cnt <= 4'd8))
            shift_reg <= {data_bit, shift_reg[7:1]};
        if (clk_fall && (bit_cnt == 4'd9))
            parity_bit <= data_bit;
        if (frame_ok)
            byte_data <= shift_reg;
    end

endmodule

/* verilog/mouse_tracker.sv */
// ==============================
// three-byte packets only, no wheel byte
// pointer is clamped to the 640x480 active area
// ==============================
`timescale 1ns/1ps
`include "mouse_gui_params.svh"

module mouse_tracker
    import mouse_gui_pkg::*;
(
    input  logic         clk_pixel,
    input  logic         rst_n,
    input  logic [7:0]   byte_data,
    input  logic         byte_valid,
    output mouse_state_t mouse,
    output logic         packet_valid
);

    typedef enum logic [1:0] {
        WAIT_HDR,
        WAIT_DX,
        WAIT_DY
    } pkt_state_t;

    pkt_state_t         state;
    logic [7:0]         hdr;
    logic [7:0]         dx_low;
    logic signed [11:0] dx;
    logic signed [11:0] dy;
    logic signed [11:0] x_next;
    logic signed [11:0] y_next;
    logic [9:0]         x_clamped;
    logic [9:0]         y_clamped;
    logic               overflow;

    function automatic logic [9:0] clamp_pos(input logic signed [11:0] pos,
                                             input logic [9:0] limit);
        logic [9:0] result;
        if (pos < 0)
            result = '0;
        else if (pos > $signed({2'b00, limit}))
            result = limit;
        else
            result = pos[9:0];
        return result;
    endfunction

    // 9-bit movement, sign bits live in the header
    assign dx = {{4{hdr[4]}}, dx_low};
    assign dy = {{4{hdr[5]}}, byte_data};

    // screen y grows downward while PS/2 y grows upward
    assign x_next = $signed({2'b00, mouse.x}) + dx;
    assign y_next = $signed({2'b00, mouse.y}) - dy;

    assign x_clamped = clamp_pos(x_next, 10'(`H_ACTIVE - 1));
    assign y_clamped = clamp_pos(y_next, 10'(`V_ACTIVE - 1));
    assign overflow  = hdr[7] | hdr[6];

    always_ff @(posedge clk_pixel or negedge rst_n)
    begin
        if (!rst_n)
        begin
            state        <= WAIT_HDR;
            mouse        <= '0;
            packet_valid <= 1'b0;
        end
        else
        begin
            packet_valid <= 1'b0;
            if (byte_valid)
            begin
                case (state)
                    // bit 3 is always set in a real header, use it to resync
                    WAIT_HDR: if (byte_data[3]) state <= WAIT_DX;
                    WAIT_DX:  state <= WAIT_DY;
                    WAIT_DY:
                    begin
                        state         <= WAIT_HDR;
                        packet_valid  <= 1'b1;
                        mouse.buttons <= buttons_t'(hdr[2:0]);
                        if (!overflow)
                        begin
                            mouse.x <= x_clamped;
                            mouse.y <= y_clamped;
                        end
                    end
                    default:  state <= WAIT_HDR;
                endcase
            end
        end
    end

    always_ff @(posedge clk_pixel)
    begin
        if (byte_valid && (state == WAIT_HDR))
            hdr <= byte_data;
        if (byte_valid && (state == WAIT_DX))
            dx_low <= byte_data;
    end

endmodule

/* verilog/video_timing.sv */
// ==============================
// fixed 640x480 timing, one pixel per clock
// beam fields are decoded straight from the counters
// ==============================
`timescale 1ns/1ps
`include "mouse_gui_params.svh"

module video_timing
    import mouse_gui_pkg::*;
(
    input  logic  clk_pixel,
    input  logic  rst_n,
    output beam_t beam
);

    logic [9:0] h_cnt;
    logic [9:0] v_cnt;
    logic       h_last;
    logic       v_last;

    assign h_last = (h_cnt == 10'(`H_TOTAL - 1));
    assign v_last = (v_cnt == 10'(`V_TOTAL - 1));

    always_ff @(posedge clk_pixel or negedge rst_n)
    begin
        if (!rst_n)
        begin
            h_cnt <= '0;
            v_cnt <= '0;
        end
        else if (h_last)
        begin
            h_cnt <= '0;
            // line count steps only at the end of a line
            if (v_last)
                v_cnt <= '0;
            else
                v_cnt <= v_cnt + 10'd1;
        end
        else
        begin
            h_cnt <= h_cnt + 10'd1;
        end
    end

    always_comb
    begin
        beam.x     = h_cnt;
        beam.y     = v_cnt;
        // sync pulses are active low
        beam.hsync = !((h_cnt >= 10'(`H_SYNC_START)) && (h_cnt < 10'(`H_SYNC_END)));
        beam.vsync = !((v_cnt >= 10'(`V_SYNC_START)) && (v_cnt < 10'(`V_SYNC_END)));
        beam.blank = (h_cnt >= 10'(`H_ACTIVE)) || (v_cnt >= 10'(`V_ACTIVE));
    end

endmodule

/* verilog/block_canvas.sv */
// ==============================
// table starts all black from power-up init, reset does not clear it
// pixel output lags the incoming beam by one cycle
// ==============================
`timescale 1ns/1ps
`include "mouse_gui_params.svh"

module block_canvas
    import mouse_gui_pkg::*;
(
    input  logic         clk_pixel,
    input  logic         rst_n,
    input  beam_t        beam,
    input  mouse_state_t mouse,
    output pixel_out_t   pixel
);

    localparam int ADDR_BITS = (10 - `BLOCK_X_SHIFT) + (10 - `BLOCK_Y_SHIFT);

    color_t               color_table [0:(1 << ADDR_BITS)-1];
    logic [ADDR_BITS-1:0] wr_addr;
    logic [ADDR_BITS-1:0] rd_addr;
    color_t               rd_color;
    color_t               next_color;
    logic                 on_crosshair;

    initial
    begin
        for (int i = 0; i < (1 << ADDR_BITS); i++)
            color_table[i] = '0;
    end

    // block address is {row, column}
    assign wr_addr = {mouse.y[9:`BLOCK_Y_SHIFT], mouse.x[9:`BLOCK_X_SHIFT]};
    assign rd_addr = {beam.y[9:`BLOCK_Y_SHIFT], beam.x[9:`BLOCK_X_SHIFT]};

    // left paints with the beam row, which looks random, right erases
    always_ff @(posedge clk_pixel)
    begin
        if (mouse.buttons.left)
            color_table[wr_addr] <= color_t'(beam.y[8:0]);
        else if (mouse.buttons.right)
            color_table[wr_addr] <= '0;
    end

    // read sees the old entry when a write hits the same address
    assign rd_color     = color_table[rd_addr];
    assign on_crosshair = (beam.x == mouse.x) || (beam.y == mouse.y);

    always_comb
    begin
        if (beam.blank)
            next_color = '0;
        else if (on_crosshair)
            next_color = color_t'(`CROSSHAIR_COLOR);
        else
            next_color = rd_color;
    end

    always_ff @(posedge clk_pixel or negedge rst_n)
    begin
        if (!rst_n)
        begin
            pixel            <= '0;
            pixel.beam.hsync <= 1'b1;
            pixel.beam.vsync <= 1'b1;
            pixel.beam.blank <= 1'b1;
        end
        else
        begin
            pixel.beam  <= beam;
            pixel.color <= next_color;
        end
    end

endmodule

/* verilog/mouse_gui_top.sv */
// ==============================
// ends at RGB 3:3:3 with sync and blank, no TMDS stage
// ==============================
`timescale 1ns/1ps

module mouse_gui_top
    import mouse_gui_pkg::*;
(
    input  logic         clk_pixel,
    input  logic         rst_n,
    input  logic         ps2_clk,
    input  logic         ps2_data,
    output pixel_out_t   pixel,
    output mouse_state_t mouse,
    output logic         packet_valid
);

    logic [7:0] byte_data;
    logic       byte_valid;
    beam_t      beam;

    ps2_frame_rx i_rx
    (
        .clk_pixel  (clk_pixel),
        .rst_n      (rst_n),
        .ps2_clk    (ps2_clk),
        .ps2_data   (ps2_data),
        .byte_data  (byte_data),
        .byte_valid (byte_valid)
    );

    mouse_tracker i_tracker
    (
        .clk_pixel    (clk_pixel),
        .rst_n        (rst_n),
        .byte_data    (byte_data),
        .byte_valid   (byte_valid),
        .mouse        (mouse),
        .packet_valid (packet_valid)
    );

    video_timing i_timing
    (
        .clk_pixel (clk_pixel),
        .rst_n     (rst_n),
        .beam      (beam)
    );

    // canvas reads the pointer level directly, buttons act every cycle they are held
    block_canvas i_canvas
    (
        .clk_pixel (clk_pixel),
        .rst_n     (rst_n),
        .beam      (beam),
        .mouse     (mouse),
        .pixel     (pixel)
    );

endmodule

/* verification/tb_mouse_gui_model.sv */
// ==============================
// reference model of pointer, block table and registered pixel
// pointer update is timed by the DUT packet strobe, values come from the packet bytes
// ==============================
`timescale 1ns/1ps
`include "mouse_gui_params.svh"

module tb_mouse_gui_model
    import mouse_gui_pkg::*;
(
    input  logic         clk_pixel,
    input  logic         rst_n,
    input  logic         packet_valid,
    input  logic [7:0]   pkt_hdr,
    input  logic [7:0]   pkt_dx,
    input  logic [7:0]   pkt_dy,
    output mouse_state_t ptr_now,
    output pixel_out_t   pixel_exp
);

    color_t       table_mem [0:2047];
    mouse_state_t ptr;
    int           h;
    int           v;
    int           raddr;
    int           waddr;

    function automatic mouse_state_t next_state(input mouse_state_t cur, input logic [7:0] hdr,
                                                input logic [7:0] bx, input logic [7:0] by);
        mouse_state_t res;
        int           nx;
        int           ny;
        res                = cur;
        res.buttons.left   = hdr[0];
        res.buttons.right  = hdr[1];
        res.buttons.middle = hdr[2];
        nx = int'(cur.x) + (hdr[4] ? int'(bx) - 256 : int'(bx));
        // PS/2 y points up, screen y points down
        ny = int'(cur.y) - (hdr[5] ? int'(by) - 256 : int'(by));
        if (hdr[7:6] == 2'b00)
        begin
            res.x = 10'((nx < 0) ? 0 : ((nx > `H_ACTIVE - 1) ? `H_ACTIVE - 1 : nx));
            res.y = 10'((ny < 0) ? 0 : ((ny > `V_ACTIVE - 1) ? `V_ACTIVE - 1 : ny));
        end
        return res;
    endfunction

    initial
    begin
        for (int i = 0; i < 2048; i++)
            table_mem[i] = '0;
    end

    assign ptr_now = packet_valid ? next_state(ptr, pkt_hdr, pkt_dx, pkt_dy) : ptr;
    // 32 blocks per row in the address map
    assign raddr   = (v / 16) * 32 + (h / 32);
    assign waddr   = (int'(ptr_now.y) / 16) * 32 + (int'(ptr_now.x) / 32);

    always @(posedge clk_pixel or negedge rst_n)
    begin
        if (!rst_n)
        begin
            h                    <= 0;
            v                    <= 0;
            ptr                  <= '0;
            pixel_exp            <= '0;
            pixel_exp.beam.hsync <= 1'b1;
            pixel_exp.beam.vsync <= 1'b1;
            pixel_exp.beam.blank <= 1'b1;
        end
        else
        begin
            pixel_exp.beam.x     <= 10'(h);
            pixel_exp.beam.y     <= 10'(v);
            pixel_exp.beam.hsync <= !(h >= `H_SYNC_START && h < `H_SYNC_END);
            pixel_exp.beam.vsync <= !(v >= `V_SYNC_START && v < `V_SYNC_END);
            pixel_exp.beam.blank <= (h >= `H_ACTIVE) || (v >= `V_ACTIVE);
            if (h >= `H_ACTIVE || v >= `V_ACTIVE)
                pixel_exp.color <= '0;
            else if (h == int'(ptr_now.x) || v == int'(ptr_now.y))
                pixel_exp.color <= color_t'(`CROSSHAIR_COLOR);
            else
                pixel_exp.color <= table_mem[raddr];
            // table read above sees the entry before this write
            if (ptr_now.buttons.left)
                table_mem[waddr] <= color_t'(9'(v));
            else if (ptr_now.buttons.right)
                table_mem[waddr] <= '0;
            h   <= (h == `H_TOTAL - 1) ? 0 : h + 1;
            if (h == `H_TOTAL - 1)
                v <= (v == `V_TOTAL - 1) ? 0 : v + 1;
            ptr <= ptr_now;
        end
    end

endmodule

/* verification/tb_mouse_gui.sv */
// ==============================
// PS/2 frames are bit-banged at 20 pixel clocks per bit
// every output pixel is compared with the model once reset is released
// ==============================
`timescale 1ns/1ps
`include "mouse_gui_params.svh"

module tb_mouse_gui
    import mouse_gui_pkg::*;
();

    localparam int    FRAME_CYCLES = `H_TOTAL * `V_TOTAL;
    localparam int    BIT_CYCLES   = 20;
    localparam int    BYTE_CYCLES  = (`PS2_FRAME_BITS + 1) * BIT_CYCLES;
    localparam int    NUM_TESTS    = 5;
    localparam int    MAX_BYTES    = 200;
    localparam longint WATCHDOG_NS =
        (longint'(NUM_TESTS) * 4 * FRAME_CYCLES + MAX_BYTES * BYTE_CYCLES) * 8;

    logic         clk_pixel;
    logic         rst_n;
    logic         ps2_clk;
    logic         ps2_data;
    pixel_out_t   pixel;
    mouse_state_t mouse;
    logic         packet_valid;
    logic [7:0]   pkt_hdr;
    logic [7:0]   pkt_dx;
    logic [7:0]   pkt_dy;
    mouse_state_t ptr_model;
    pixel_out_t   pixel_exp;
    pixel_out_t   rst_px;
    mouse_state_t mouse_seen;
    mouse_state_t model_seen;
    logic [15:0]  lfsr;
    logic [15:0]  r1;
    logic [15:0]  r2;
    logic [15:0]  r3;
    int           errors = 0;
    int           tests_failed = 0;
    int           pv_count = 0;

    mouse_gui_top i_dut
    (
        .clk_pixel    (clk_pixel),
        .rst_n        (rst_n),
        .ps2_clk      (ps2_clk),
        .ps2_data     (ps2_data),
        .pixel        (pixel),
        .mouse        (mouse),
        .packet_valid (packet_valid)
    );

    tb_mouse_gui_model i_model
    (
        .clk_pixel    (clk_pixel),
        .rst_n        (rst_n),
        .packet_valid (packet_valid),
        .pkt_hdr      (pkt_hdr),
        .pkt_dx       (pkt_dx),
        .pkt_dy       (pkt_dy),
        .ptr_now      (ptr_model),
        .pixel_exp    (pixel_exp)
    );

    initial
    begin
        clk_pixel = 1'b0;
    end

    always #4 clk_pixel = ~clk_pixel;

    initial
    begin
        #(WATCHDOG_NS);
        $display("Timeout: the tests did not complete within %0d ns", WATCHDOG_NS);
        $display("Testbench failed");
        $finish;
    end

    task automatic check_mouse(input string name, input mouse_state_t got,
                               input mouse_state_t exp);
        if (got !== exp)
        begin
            errors++;
            $display("Mismatch at %0t ns: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_pixel(input string name, input pixel_out_t got,
                               input pixel_out_t exp);
        if (got !== exp)
        begin
            errors++;
            $display("Mismatch at %0t ns: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_count(input string name, input int got, input int exp);
        if (got != exp)
        begin
            errors++;
            $display("Mismatch at %0t ns: %s got %0d expected %0d", $time, name, got, exp);
        end
    endtask

    // whole video output against the model
    always @(negedge clk_pixel)
    begin
        if (rst_n)
            check_pixel("pixel", pixel, pixel_exp);
    end

    always @(negedge clk_pixel)
    begin
        if (rst_n && packet_valid)
        begin
            pv_count++;
            mouse_seen = mouse;
            model_seen = ptr_model;
        end
    end

    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    task automatic take_bits(input int n, output logic [15:0] val);
        val = '0;
        for (int i = 0; i < n; i++)
        begin
            lfsr = lfsr_next(lfsr);
            val  = {val[14:0], lfsr[0]};
        end
    endtask

    task automatic tick(input int n);
        repeat (n) @(posedge clk_pixel);
        #1;
    endtask

    task automatic send_frame(input logic [7:0] b, input bit bad_parity, input bit bad_stop);
        logic [10:0] frame;
        // stop, odd parity, data LSB first, start
        frame = {~bad_stop, (~^b) ^ bad_parity, b, 1'b0};
        for (int i = 0; i < `PS2_FRAME_BITS; i++)
        begin
            ps2_data = frame[i];
            tick(BIT_CYCLES / 2);
            ps2_clk = 1'b0;
            tick(BIT_CYCLES / 2);
            ps2_clk = 1'b1;
        end
        ps2_data = 1'b1;
        tick(BIT_CYCLES);
    endtask

    task automatic send_packet(input logic [7:0] hdr, input logic [7:0] bx, input logic [7:0] by);
        int start;
        int waited;
        start   = pv_count;
        pkt_hdr = hdr;
        pkt_dx  = bx;
        pkt_dy  = by;
        send_frame(hdr, 1'b0, 1'b0);
        send_frame(bx, 1'b0, 1'b0);
        send_frame(by, 1'b0, 1'b0);
        waited = 0;
        while (pv_count == start && waited < 4 * BIT_CYCLES)
        begin
            @(negedge clk_pixel);
            waited++;
        end
        if (pv_count == start)
        begin
            errors++;
            $display("Error at %0t ns: no packet_valid after a complete packet", $time);
        end
        else
        begin
            check_count("packet_valid", pv_count - start, 1);
            check_mouse("mouse", mouse_seen, model_seen);
        end
        tick(1);
    endtask

    task automatic end_test(input string name, input int err_start);
        if (errors == err_start)
            $display("test %s: ok", name);
        else
        begin
            tests_failed++;
            $display("test %s: %0d errors", name, errors - err_start);
        end
    endtask

    initial
    begin
        int err_start;
        int start;
        rst_n    = 1'b0;
        ps2_clk  = 1'b1;
        ps2_data = 1'b1;
        pkt_hdr  = '0;
        pkt_dx   = '0;
        pkt_dy   = '0;
        lfsr     = 16'd15195;
        rst_px   = '0;
        rst_px.beam.hsync = 1'b1;
        rst_px.beam.vsync = 1'b1;
        rst_px.beam.blank = 1'b1;

        // reset values are checked while reset is still held
        err_start = errors;
        tick(7);
        @(negedge clk_pixel);
        check_pixel("pixel", pixel, rst_px);
        check_mouse("mouse", mouse, '0);
        check_count("packet_valid", int'(packet_valid), 0);
        tick(1);
        rst_n = 1'b1;
        tick(2 * FRAME_CYCLES);
        end_test("reset and timing", err_start);

        err_start = errors;
        for (int i = 0; i < 20; i++)
        begin
            take_bits(9, r1);
            take_bits(9, r2);
            take_bits(1, r3);
            send_packet({2'b00, r2[8], r1[8], 1'b1, r3[0], 2'b00}, r1[7:0], r2[7:0]);
        end
        // full pushes to the bottom left and then the top right
        for (int i = 0; i < 3; i++)
            send_packet(8'h38, 8'h00, 8'h00);
        for (int i = 0; i < 3; i++)
            send_packet(8'h08, 8'hFF, 8'hFF);
        end_test("movement and clamping", err_start);

        err_start = errors;
        for (int i = 0; i < 4; i++)
        begin
            start = pv_count;
            take_bits(16, r1);
            send_frame(r1[7:0], 1'b1, 1'b0);
            send_frame(r1[15:8], 1'b0, 1'b1);
            send_frame(r1[7:0] & 8'hF7, 1'b0, 1'b0);
            tick(4 * BIT_CYCLES);
            check_count("packet_valid", pv_count - start, 0);
            take_bits(18, r2);
            send_packet({2'b00, r2[17:16], 4'b1000}, r2[7:0], r2[15:8]);
        end
        end_test("corrupt frames", err_start);

        err_start = errors;
        for (int i = 0; i < 6; i++)
        begin
            take_bits(16, r1);
            take_bits(5, r2);
            if (r2[4:3] == 2'b00)
                r2[3] = 1'b1;
            send_packet({r2[4:3], r1[1:0], 1'b1, r2[2:0]}, r1[15:8], r1[9:2]);
        end
        send_packet(8'h08, 8'h00, 8'h00);
        end_test("overflow packets", err_start);

        err_start = errors;
        for (int i = 0; i < 8; i++)
        begin
            take_bits(16, r1);
            take_bits(3, r2);
            // left paints at a new spot and right sometimes erases the same block
            send_packet({2'b00, r2[1:0], 2'b10, 2'b01}, r1[7:0], r1[15:8]);
            tick(2000);
            if (r2[2])
            begin
                send_packet(8'h0A, 8'h00, 8'h00);
                tick(2000);
            end
        end
        send_packet(8'h08, 8'h00, 8'h00);
        // one whole frame after the release
        tick(FRAME_CYCLES + `H_TOTAL);
        end_test("paint and erase", err_start);

        $display("tests run %0d, failed %0d, errors %0d", NUM_TESTS, tests_failed, errors);
        if (errors == 0)
            $display("Testbench passed");
        else
            $display("Testbench failed");
        $finish;
    end

endmodule

/* mouse_gui.f */
+incdir+verilog
verilog/mouse_gui_pkg.sv
verilog/ps2_frame_rx.sv
verilog/mouse_tracker.sv
verilog/video_timing.sv
verilog/block_canvas.sv
verilog/mouse_gui_top.sv
verification/tb_mouse_gui_model.sv
verification/tb_mouse_gui.sv
